//--- axi_ser_pkg.sv
/*
 * Shared widths and the atomic opcode enum of the ID serializer subsystem,
 * single-beat AW, W, B, AR and R channel structs and the request/response bundles
 */
package axi_ser_pkg;

  // Upstream transaction ID width
  // The struct layouts below depend on it
  localparam int unsigned id_w = 4;
  // Word address width
  localparam int unsigned addr_w = 8;
  // Data width of one beat
  localparam int unsigned data_w = 32;

  // Atomic opcode carried on AW
  // Only ATOP_ADD returns a read response
  typedef enum logic [1:0] {
    ATOP_NONE  = 2'd0,
    ATOP_STORE = 2'd1,
    ATOP_ADD   = 2'd2
  } atop_e;

  // Write address channel, 14 bits
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    atop_e             atop;
  } aw_chan_t;

  // Write data channel, single beat so no strobe or last
  typedef struct packed {
    logic [data_w-1:0] data;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    logic [id_w-1:0] id;
  } b_chan_t;

  // Read address channel, 12 bits
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
  } ar_chan_t;

  // Read data channel, last is always set
  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [data_w-1:0] data;
    logic              last;
  } r_chan_t;

  // Everything the manager side drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything the subordinate side drives
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_rsp_t;

endpackage

//--- id_fifo.sv
/*
 * Circular ID queue without fall-through, with full and empty flags
 * and checks against overflow and underflow
 */
module id_fifo #(
  parameter int unsigned depth = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  logic [axi_ser_pkg::id_w-1:0] data_i,
  input  logic                         pop_i,
  output logic [axi_ser_pkg::id_w-1:0] data_o,
  output logic                         full_o,
  output logic                         empty_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  logic [axi_ser_pkg::id_w-1:0] mem_q [depth];
  logic [ptr_w-1:0]             wr_ptr_q;
  logic [ptr_w-1:0]             rd_ptr_q;
  logic [cnt_w-1:0]             count_q;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  // Head of queue, a new entry shows up one cycle after its push
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at depth, not at a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + ptr_w'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + ptr_w'(1);
      end
      // Occupancy only moves when exactly one side acts
      if (push_i && !pop_i) begin
        count_q <= count_q + cnt_w'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - cnt_w'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The serializer gates its handshakes with these flags
  no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      full_o |-> !push_i)
    else $error("ID queue pushed while full");
  no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      empty_o |-> !pop_i)
    else $error("ID queue popped while empty");

endmodule

//--- axi_serializer.sv
/*
 * ID serializer: forwards every transaction on ID zero, restores response IDs
 * from a read and a write ID queue and isolates atomics with a drain FSM
 */
module axi_serializer #(
  parameter int unsigned max_read_txns  = 4,
  parameter int unsigned max_write_txns = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_ser_pkg::axi_req_t slv_req_i,
  output axi_ser_pkg::axi_rsp_t slv_rsp_o,
  output axi_ser_pkg::axi_req_t mst_req_o,
  input  axi_ser_pkg::axi_rsp_t mst_rsp_i
);

  typedef enum logic [1:0] {
    ATOP_IDLE    = 2'b00,
    ATOP_DRAIN   = 2'b01,
    ATOP_EXECUTE = 2'b10
  } state_e;

  state_e                       state_q;
  state_e                       state_d;
  logic                         rd_push;
  logic                         rd_pop;
  logic                         rd_full;
  logic                         rd_empty;
  logic                         wr_push;
  logic                         wr_pop;
  logic                         wr_full;
  logic                         wr_empty;
  logic [axi_ser_pkg::id_w-1:0] rd_push_id;
  logic [axi_ser_pkg::id_w-1:0] r_id;
  logic [axi_ser_pkg::id_w-1:0] b_id;
  logic                         aw_is_atop;
  logic                         atop_has_r;
  logic                         up_b_valid;
  logic                         up_r_valid;

  assign aw_is_atop = (slv_req_i.aw.atop != axi_ser_pkg::ATOP_NONE);
  // Only the add returns read data
  assign atop_has_r = (slv_req_i.aw.atop == axi_ser_pkg::ATOP_ADD);

  // Responses only go upstream once their ID is known
  assign up_b_valid = mst_rsp_i.b_valid & ~wr_empty;
  assign up_r_valid = mst_rsp_i.r_valid & ~rd_empty;
  assign wr_pop     = up_b_valid & slv_req_i.b_ready;
  assign rd_pop     = up_r_valid & slv_req_i.r_ready & mst_rsp_i.r.last;

  always_comb begin
    state_d    = state_q;
    rd_push    = 1'b0;
    wr_push    = 1'b0;
    rd_push_id = slv_req_i.ar.id;

    // Pass everything straight through by default
    mst_req_o = slv_req_i;
    slv_rsp_o = mst_rsp_i;

    // All traffic downstream runs on ID zero
    mst_req_o.aw.id = '0;
    mst_req_o.ar.id = '0;
    // Original IDs come back from the queue heads
    slv_rsp_o.b.id  = b_id;
    slv_rsp_o.r.id  = r_id;

    // Address handshakes are opened per state below
    mst_req_o.aw_valid = 1'b0;
    slv_rsp_o.aw_ready = 1'b0;
    mst_req_o.ar_valid = 1'b0;
    slv_rsp_o.ar_ready = 1'b0;

    unique case (state_q)
      ATOP_IDLE, ATOP_EXECUTE: begin
        // Atomic is done once its responses have left or are leaving now
        if (state_q == ATOP_EXECUTE && (wr_empty || wr_pop) && (rd_empty || rd_pop)) begin
          state_d = ATOP_IDLE;
        end
        if (state_d == ATOP_IDLE) begin
          // Reads are held off while the read queue has no room
          mst_req_o.ar_valid = slv_req_i.ar_valid & ~rd_full;
          slv_rsp_o.ar_ready = mst_rsp_i.ar_ready & ~rd_full;
          rd_push            = mst_req_o.ar_valid & mst_rsp_i.ar_ready;
          if (slv_req_i.aw_valid) begin
            if (!aw_is_atop) begin
              // Plain write held off while the write queue has no room
              mst_req_o.aw_valid = ~wr_full;
              slv_rsp_o.aw_ready = mst_rsp_i.aw_ready & ~wr_full;
              wr_push            = mst_req_o.aw_valid & mst_rsp_i.aw_ready;
            end else if (!mst_req_o.ar_valid || mst_rsp_i.ar_ready) begin
              // Atomic seen so start draining
              // An AR already raised downstream must finish first
              state_d = ATOP_DRAIN;
            end
          end
        end
      end
      ATOP_DRAIN: begin
        // Issue the atomic alone once nothing is outstanding
        if (wr_empty && rd_empty) begin
          mst_req_o.aw_valid = 1'b1;
          slv_rsp_o.aw_ready = mst_rsp_i.aw_ready;
          wr_push            = mst_rsp_i.aw_ready;
          if (atop_has_r) begin
            // Read queue takes the AW ID for the returned old value
            rd_push_id = slv_req_i.aw.id;
            rd_push    = mst_rsp_i.aw_ready;
          end
          if (mst_rsp_i.aw_ready) begin
            state_d = ATOP_EXECUTE;
          end
        end
      end
      default: state_d = ATOP_IDLE;
    endcase

    // Response handshakes gated by queue occupancy
    slv_rsp_o.b_valid = up_b_valid;
    mst_req_o.b_ready = slv_req_i.b_ready & ~wr_empty;
    slv_rsp_o.r_valid = up_r_valid;
    mst_req_o.r_ready = slv_req_i.r_ready & ~rd_empty;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ATOP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read ID queue
  id_fifo #(
    .depth ( max_read_txns )
  ) i_rd_id_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( rd_push    ),
    .data_i  ( rd_push_id ),
    .pop_i   ( rd_pop     ),
    .data_o  ( r_id       ),
    .full_o  ( rd_full    ),
    .empty_o ( rd_empty   )
  );

  // Write ID queue including atomics
  id_fifo #(
    .depth ( max_write_txns )
  ) i_wr_id_fifo (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .push_i  ( wr_push         ),
    .data_i  ( slv_req_i.aw.id ),
    .pop_i   ( wr_pop          ),
    .data_o  ( b_id            ),
    .full_o  ( wr_full         ),
    .empty_o ( wr_empty        )
  );

  // Downstream AW only ever carries an upstream AW, also out of the drain
  aw_lost : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (slv_req_i.aw_valid & slv_rsp_o.aw_ready) == (mst_req_o.aw_valid & mst_rsp_i.aw_ready))
    else $error("AW beat lost or made up");
  // Single beat writes, a W is only taken together with its own AW
  w_lost : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (slv_req_i.w_valid & slv_rsp_o.w_ready) == (slv_req_i.aw_valid & slv_rsp_o.aw_ready))
    else $error("W beat lost or taken without its AW");
  // A B from the target needs a queued ID or it would be stuck
  b_lost : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_rsp_i.b_valid |-> !wr_empty)
    else $error("B beat lost");
  // Every accepted AR leaves its ID in the read queue
  ar_lost : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_req_i.ar_valid & slv_rsp_o.ar_ready |=> !rd_empty)
    else $error("AR beat lost");
  // An R from the target needs a queued ID or it would be stuck
  r_lost : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_rsp_i.r_valid |-> !rd_empty)
    else $error("R beat lost");

endmodule

//--- mem_target.sv
/*
 * In-order word memory on ID zero, one write and one read outstanding,
 * executing plain writes, reads and the store and add atomics
 */
module mem_target #(
  parameter int unsigned mem_words = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_ser_pkg::axi_req_t req_i,
  output axi_ser_pkg::axi_rsp_t rsp_o
);

  localparam int unsigned idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

  logic [axi_ser_pkg::data_w-1:0] mem_q [mem_words];
  logic [idx_w-1:0]               aw_idx;
  logic [idx_w-1:0]               ar_idx;
  logic                           is_add;
  logic                           wr_ok;
  logic                           ar_ok;
  logic                           aw_hs;
  logic                           ar_hs;
  logic                           b_pend_q;
  logic                           r_pend_q;
  logic [axi_ser_pkg::id_w-1:0]   b_id_q;
  logic [axi_ser_pkg::id_w-1:0]   r_id_q;
  logic [axi_ser_pkg::data_w-1:0] r_data_q;

  assign aw_idx = idx_w'(req_i.aw.addr);
  assign ar_idx = idx_w'(req_i.ar.addr);
  assign is_add = (req_i.aw.atop == axi_ser_pkg::ATOP_ADD);

  // Writes wait for the pending B and an add also for the pending R
  assign wr_ok = ~b_pend_q & ~(is_add & r_pend_q);
  // Reads yield to an add on AW since both return on R
  assign ar_ok = ~r_pend_q & ~(req_i.aw_valid & is_add);
  // AW and W are taken together
  assign aw_hs = req_i.aw_valid & req_i.w_valid & wr_ok;
  assign ar_hs = req_i.ar_valid & ar_ok;

  always_comb begin
    rsp_o.aw_ready = req_i.w_valid & wr_ok;
    rsp_o.w_ready  = req_i.aw_valid & wr_ok;
    rsp_o.b.id     = b_id_q;
    rsp_o.b_valid  = b_pend_q;
    rsp_o.ar_ready = ar_ok;
    rsp_o.r.id     = r_id_q;
    rsp_o.r.data   = r_data_q;
    rsp_o.r.last   = 1'b1;
    rsp_o.r_valid  = r_pend_q;
  end

  // Response flags are raised the cycle after acceptance and held until taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        b_pend_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_pend_q <= 1'b0;
      end
      if (ar_hs || (aw_hs && is_add)) begin
        r_pend_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // Response payload with IDs echoed from the request
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      b_id_q <= req_i.aw.id;
    end
    if (ar_hs) begin
      r_id_q   <= req_i.ar.id;
      r_data_q <= mem_q[ar_idx];
    end else if (aw_hs && is_add) begin
      // Add returns the word as it was before the update
      r_id_q   <= req_i.aw.id;
      r_data_q <= mem_q[aw_idx];
    end
  end

  // Word array cleared on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < mem_words; i++) begin
        mem_q[i] <= '0;
      end
    end else if (aw_hs) begin
      // Store and plain write take W data as is
      mem_q[aw_idx] <= is_add ? mem_q[aw_idx] + req_i.w.data : req_i.w.data;
    end
  end

  // A W waiting for its AW stays valid and unchanged until both are taken
  aw_w_paired : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i.w_valid & ~rsp_o.w_ready |=> req_i.w_valid & $stable(req_i.w))
    else $error("W dropped or changed before it was taken with its AW");

endmodule

//--- ser_top.sv
/*
 * Top level, ID serializer in front of the memory target
 */
module ser_top #(
  parameter int unsigned max_read_txns  = 4,
  parameter int unsigned max_write_txns = 4,
  parameter int unsigned mem_words      = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_ser_pkg::axi_req_t slv_req_i,
  output axi_ser_pkg::axi_rsp_t slv_rsp_o
);

  // Downstream bus on ID zero
  axi_ser_pkg::axi_req_t mst_req;
  axi_ser_pkg::axi_rsp_t mst_rsp;

  axi_serializer #(
    .max_read_txns  ( max_read_txns  ),
    .max_write_txns ( max_write_txns )
  ) i_axi_serializer (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .slv_req_i ( slv_req_i ),
    .slv_rsp_o ( slv_rsp_o ),
    .mst_req_o ( mst_req   ),
    .mst_rsp_i ( mst_rsp   )
  );

  mem_target #(
    .mem_words ( mem_words )
  ) i_mem_target (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( mst_req ),
    .rsp_o   ( mst_rsp )
  );

endmodule

//--- tb_ser_top.sv
/*
 * Testbench for the ID serializer subsystem with clock, reset, bus driver tasks,
 * B and R collectors, a reference memory model, directed tests and a watchdog
 */
module tb_ser_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_tests = 6;
  localparam int test_ns   = 2000;
  localparam int resp_wait = 200;

  logic                           clk;
  logic                           rst_n;
  axi_ser_pkg::axi_req_t          req;
  axi_ser_pkg::axi_rsp_t          rsp;
  // Expected memory contents updated in issue order
  logic [axi_ser_pkg::data_w-1:0] model [2**axi_ser_pkg::addr_w];
  logic [axi_ser_pkg::id_w-1:0]   exp_b_id [$];
  logic [axi_ser_pkg::id_w-1:0]   exp_r_id [$];
  logic [axi_ser_pkg::data_w-1:0] exp_r_data [$];
  logic [axi_ser_pkg::id_w-1:0]   got_b_id [$];
  logic [axi_ser_pkg::id_w-1:0]   got_r_id [$];
  logic [axi_ser_pkg::data_w-1:0] got_r_data [$];
  int                             errors;
  int                             checks;
  int                             seed;
  int                             gap_seed;
  logic                           rand_ready;

  ser_top #(
    .max_read_txns  ( 4   ),
    .max_write_txns ( 4   ),
    .mem_words      ( 256 )
  ) uut (
    .clk_i     ( clk   ),
    .rst_n_i   ( rst_n ),
    .slv_req_i ( req   ),
    .slv_rsp_o ( rsp   )
  );

  always #2 clk = ~clk;

  // Record every upstream B and R beat in arrival order
  always @(posedge clk) begin
    if (rst_n && rsp.b_valid && req.b_ready) begin
      got_b_id.push_back(rsp.b.id);
    end
    if (rst_n && rsp.r_valid && req.r_ready) begin
      got_r_id.push_back(rsp.r.id);
      got_r_data.push_back(rsp.r.data);
      assert (rsp.r.last) else begin
        errors++;
        $display("R beat arrived without last set");
      end
    end
  end

  // Random ready gaps on B and R during the mixed test
  always @(negedge clk) begin
    if (rand_ready) begin
      req.b_ready = (($random(gap_seed) & 3) != 0);
      req.r_ready = (($random(gap_seed) & 3) != 0);
    end
  end

  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // Called on a falling edge and returns on the falling edge after the AW handshake
  // W has to be taken in the same cycle as its AW and never on its own
  task automatic wait_aw();
    logic aw_rdy;
    do begin
      @(posedge clk);
      aw_rdy = rsp.aw_ready;
      checks++;
      assert (rsp.w_ready === aw_rdy) else begin
        errors++;
        $display("W ready did not follow AW ready while a write was waiting");
      end
    end while (!aw_rdy);
    @(negedge clk);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
  endtask

  task automatic do_write(input logic [3:0] id, input logic [7:0] addr, input logic [31:0] data);
    req.aw.id    = id;
    req.aw.addr  = addr;
    req.aw.atop  = axi_ser_pkg::ATOP_NONE;
    req.aw_valid = 1'b1;
    req.w.data   = data;
    req.w_valid  = 1'b1;
    wait_aw();
    model[addr] = data;
    exp_b_id.push_back(id);
  endtask

  task automatic do_atomic(input axi_ser_pkg::atop_e op, input logic [3:0] id,
                           input logic [7:0] addr, input logic [31:0] data);
    req.aw.id    = id;
    req.aw.addr  = addr;
    req.aw.atop  = op;
    req.aw_valid = 1'b1;
    req.w.data   = data;
    req.w_valid  = 1'b1;
    wait_aw();
    exp_b_id.push_back(id);
    if (op == axi_ser_pkg::ATOP_ADD) begin
      // Old value comes back on R
      exp_r_id.push_back(id);
      exp_r_data.push_back(model[addr]);
      model[addr] = model[addr] + data;
    end else begin
      model[addr] = data;
    end
  endtask

  task automatic do_read(input logic [3:0] id, input logic [7:0] addr);
    req.ar.id    = id;
    req.ar.addr  = addr;
    req.ar_valid = 1'b1;
    do @(posedge clk); while (!rsp.ar_ready);
    @(negedge clk);
    req.ar_valid = 1'b0;
    exp_r_id.push_back(id);
    exp_r_data.push_back(model[addr]);
  endtask

  // Wait for all expected beats and a few more cycles to catch extra ones
  task automatic wait_resp();
    int cycles;
    cycles = 0;
    while ((got_b_id.size() < exp_b_id.size() || got_r_id.size() < exp_r_id.size())
           && cycles < resp_wait) begin
      @(negedge clk);
      cycles++;
    end
    assert (cycles < resp_wait) else begin
      errors++;
      $display("Timed out waiting for B or R beats");
    end
    repeat (4) @(negedge clk);
  endtask

  // Per-direction ID order and read data against the expected queues
  task automatic check_resp(input string name);
    logic [31:0] exp_id;
    logic [31:0] exp_data;
    while (exp_b_id.size() > 0 && got_b_id.size() > 0) begin
      check_val(name, "B id", exp_b_id.pop_front(), got_b_id.pop_front());
    end
    while (exp_r_id.size() > 0 && got_r_id.size() > 0) begin
      exp_id   = exp_r_id.pop_front();
      exp_data = exp_r_data.pop_front();
      check_val(name, "R id", exp_id, got_r_id.pop_front());
      check_val(name, "R data", exp_data, got_r_data.pop_front());
    end
    checks++;
    assert (exp_b_id.size() + got_b_id.size() + exp_r_id.size() + got_r_id.size() == 0)
    else begin
      errors++;
      $display("%s: B or R beats missing or unexpected", name);
    end
    exp_b_id.delete();
    got_b_id.delete();
    exp_r_id.delete();
    exp_r_data.delete();
    got_r_id.delete();
    got_r_data.delete();
  endtask

  task automatic test_write_read();
    do_write(4'd5, 8'h10, 32'hcafe_0001);
    do_read(4'd9, 8'h10);
    wait_resp();
    check_resp("write_read");
  endtask

  task automatic test_read_order();
    do_read(4'd1, 8'h10);
    do_read(4'd2, 8'h20);
    do_read(4'd3, 8'h11);
    do_read(4'd4, 8'h10);
    wait_resp();
    check_resp("read_order");
  endtask

  task automatic test_add();
    do_write(4'd1, 8'h30, 32'h0000_1000);
    do_write(4'd2, 8'h31, 32'h0000_2000);
    do_write(4'd4, 8'h32, 32'h0000_3000);
    // Atomic right behind the plain writes must wait for the drain
    do_atomic(axi_ser_pkg::ATOP_ADD, 4'd3, 8'h31, 32'h0000_0100);
    do_read(4'd6, 8'h31);
    wait_resp();
    check_resp("atop_add");
  endtask

  task automatic test_store();
    do_atomic(axi_ser_pkg::ATOP_STORE, 4'd12, 8'h40, 32'hdead_beef);
    wait_resp();
    check_resp("atop_store");
    do_read(4'd13, 8'h40);
    wait_resp();
    check_resp("atop_store");
  endtask

  task automatic test_hold();
    req.b_ready = 1'b0;
    req.r_ready = 1'b0;
    do_write(4'd7, 8'h50, 32'h1234_5678);
    do_read(4'd11, 8'h50);
    // Both responses are pending and must not move while ready is low
    repeat (6) begin
      @(posedge clk);
      check_val("ready_hold", "B valid", 32'd1, 32'(rsp.b_valid));
      check_val("ready_hold", "B id", 32'd7, 32'(rsp.b.id));
      check_val("ready_hold", "R valid", 32'd1, 32'(rsp.r_valid));
      check_val("ready_hold", "R id", 32'd11, 32'(rsp.r.id));
      check_val("ready_hold", "R data", 32'h1234_5678, rsp.r.data);
    end
    @(negedge clk);
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    wait_resp();
    check_resp("ready_hold");
  endtask

  task automatic test_random();
    int          op;
    logic [3:0]  id;
    logic [7:0]  addr;
    logic [31:0] data;
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      op   = $random(seed) & 3;
      id   = 4'($random(seed));
      // Small address range so accesses hit each other
      addr = 8'($random(seed) & 15);
      data = $random(seed);
      case (op)
        0: do_write(id, addr, data);
        1: do_read(id, addr);
        2: do_atomic(axi_ser_pkg::ATOP_ADD, id, addr, data);
        default: do_atomic(axi_ser_pkg::ATOP_STORE, id, addr, data);
      endcase
    end
    rand_ready  = 1'b0;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    wait_resp();
    check_resp("random_mix");
  endtask

  // Watchdog sized from the number of tests
  initial begin
    #(num_tests * test_ns);
    $display("Watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    errors     = 0;
    checks     = 0;
    seed       = 89083;
    gap_seed   = seed + 1;
    rand_ready = 1'b0;
    for (int i = 0; i < 2**axi_ser_pkg::addr_w; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n       = 1'b1;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    test_write_read();
    test_read_order();
    test_add();
    test_store();
    test_hold();
    test_random();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
axi_ser_pkg.sv
id_fifo.sv
axi_serializer.sv
mem_target.sv
ser_top.sv
tb_ser_top.sv

//--- Bender.yml
package:
  name: ser_top

sources:
  - axi_ser_pkg.sv
  - id_fifo.sv
  - axi_serializer.sv
  - mem_target.sv
  - ser_top.sv
  - target: test
    files:
      - tb_ser_top.sv
